/* sources.f */
src/decodePkg.sv
src/instrQueue.sv
src/instrDecoder.sv
src/regFile.sv
src/operandBypass.sv
src/branchUnit.sv
src/decodeStage.sv
tb/decodeStageTb.sv

/* src/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit (
    input  decodePkg::word_t       instr,
    input  decodePkg::word_t       pc,
    input  decodePkg::word_t       rsValue,
    input  decodePkg::word_t       rtValue,
    input  decodePkg::decodeCtrl_t ctrl,
    output decodePkg::word_t       target,
    output logic                   taken
);
    import decodePkg::*;

    word_t pcPlus4;
    word_t branchOffset;
    logic  regsEqual;

    assign pcPlus4      = pc + 32'd4;
    // Word offset, sign-extended and scaled to bytes
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign regsEqual    = (rsValue == rtValue);

    // Target select
    always_comb begin
        if (ctrl.jumpReg)
            target = rsValue;
        else if (ctrl.jump)
            // Region bits come from pc plus 4
            target = {pcPlus4[31:28], instr[25:0], 2'b00};
        else
            target = pcPlus4 + branchOffset;
    end

    // Jumps always redirect
    // Branches follow the compare
    always_comb begin
        if (ctrl.jump)
            taken = 1'b1;
        else if (ctrl.branch)
            taken = ctrl.branchNe ? !regsEqual : regsEqual;
        else
            taken = 1'b0;
    end

endmodule

/* src/decodePkg.sv */
package decodePkg;

    // Register number and data word
    typedef logic [4:0]  regIdx_t;
    typedef logic [31:0] word_t;

    // ALU operations handed to execute
    typedef enum logic [3:0] {
        aluNop = 4'd0,
        aluAdd = 4'd1,
        aluSub = 4'd2,
        aluAnd = 4'd3,
        aluOr  = 4'd4,
        aluSlt = 4'd5,
        aluSll = 4'd6,
        aluLui = 4'd7
    } aluOp_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // Function codes under SPECIAL
    typedef enum logic [5:0] {
        fnSll     = 6'h00,
        fnJr      = 6'h08,
        fnSyscall = 6'h0c,
        fnAddu    = 6'h21,
        fnSubu    = 6'h23,
        fnAnd     = 6'h24,
        fnOr      = 6'h25,
        fnSlt     = 6'h2a
    } funct_t;

    // One fetched instruction with its PC
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetchEntry_t;

    // Decoder control fields
    typedef struct packed {
        logic   regDst;
        logic   link;
        logic   jump;
        logic   jumpReg;
        logic   branch;
        logic   branchNe;
        logic   signExt;
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
        logic   sys;
        aluOp_t aluOp;
    } decodeCtrl_t;

    // Forwarded result from a later stage
    typedef struct packed {
        regIdx_t dest;
        word_t   data;
        logic    valid;
    } bypass_t;

    // Packet handed to execute
    typedef struct packed {
        word_t   instr;
        word_t   pc;
        word_t   opA;
        word_t   opB;
        regIdx_t regA;
        regIdx_t regB;
        regIdx_t destReg;
        word_t   memWriteData;
        logic    regWrite;
        aluOp_t  aluOp;
        logic    memRead;
        logic    memWrite;
        logic    [4:0] shamt;
        logic    sys;
    } exePacket_t;

endpackage

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage #(
    parameter int queueDepth = 8
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  decodePkg::fetchEntry_t fetchIn,
    input  logic                   fetchValid,
    output logic                   fetchReady,
    input  decodePkg::bypass_t     wbPort,
    input  decodePkg::bypass_t     exeBypass,
    input  decodePkg::bypass_t     memBypass,
    output decodePkg::exePacket_t  exeOut,
    output logic                   exeValid,
    input  logic                   exeReady,
    output decodePkg::word_t       altPc,
    output logic                   altPcValid,
    output logic                   wantFreeze
);
    import decodePkg::*;

    fetchEntry_t head;
    logic        headValid;
    logic        accept;
    decodeCtrl_t ctrl;
    word_t       instr;
    word_t       pc;
    regIdx_t     rs;
    regIdx_t     rt;
    regIdx_t     rd;
    regIdx_t     destReg;
    word_t       rsRaw;
    word_t       rtRaw;
    word_t       destRaw;
    word_t       rsVal;
    word_t       rtVal;
    word_t       destVal;
    word_t       target;
    logic        taken;
    exePacket_t  nextPacket;

    // **************************************************************************
    // Queue and operand read
    // **************************************************************************

    // The redirect pulse flushes everything queued behind the jump
    instrQueue #(.queueDepth(queueDepth)) queue (
        .CLK      (CLK),
        .RESET    (RESET),
        .flush    (altPcValid),
        .enqData  (fetchIn),
        .enqValid (fetchValid),
        .enqReady (fetchReady),
        .deqData  (head),
        .deqValid (headValid),
        .deqReady (accept)
    );

    assign instr = head.instr;
    assign pc    = head.pc;
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];

    instrDecoder decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // rd for R-type, r31 for JAL, rt otherwise
    assign destReg = ctrl.regDst ? rd : (ctrl.link ? 5'd31 : rt);

    regFile regs (
        .CLK    (CLK),
        .RESET  (RESET),
        .readA  (rs),
        .readB  (rt),
        .readC  (destReg),
        .wbPort (wbPort),
        .dataA  (rsRaw),
        .dataB  (rtRaw),
        .dataC  (destRaw)
    );

    operandBypass rsBypass (
        .readReg   (rs),
        .rawValue  (rsRaw),
        .exeBypass (exeBypass),
        .memBypass (memBypass),
        .wbPort    (wbPort),
        .value     (rsVal)
    );

    operandBypass rtBypass (
        .readReg   (rt),
        .rawValue  (rtRaw),
        .exeBypass (exeBypass),
        .memBypass (memBypass),
        .wbPort    (wbPort),
        .value     (rtVal)
    );

    // Store data path
    operandBypass destBypass (
        .readReg   (destReg),
        .rawValue  (destRaw),
        .exeBypass (exeBypass),
        .memBypass (memBypass),
        .wbPort    (wbPort),
        .value     (destVal)
    );

    branchUnit branch (
        .instr   (instr),
        .pc      (pc),
        .rsValue (rsVal),
        .rtValue (rtVal),
        .ctrl    (ctrl),
        .target  (target),
        .taken   (taken)
    );

    // **************************************************************************
    // Packet build
    // **************************************************************************

    always_comb begin
        nextPacket.instr        = instr;
        nextPacket.pc           = pc;
        nextPacket.opA          = ctrl.link ? '0 : rsVal;
        // Return address rides on opB for link instructions
        if (ctrl.link)
            nextPacket.opB = pc + 32'd8;
        else if (ctrl.regDst || ctrl.branch)
            nextPacket.opB = rtVal;
        else if (ctrl.aluOp == aluLui)
            nextPacket.opB = {instr[15:0], 16'h0000};
        else if (ctrl.signExt)
            nextPacket.opB = {{16{instr[15]}}, instr[15:0]};
        else
            nextPacket.opB = {16'h0000, instr[15:0]};
        nextPacket.regA         = ctrl.link ? 5'd0 : rs;
        nextPacket.regB         = (ctrl.regDst || ctrl.branch) ? rt : 5'd0;
        nextPacket.destReg      = destReg;
        nextPacket.memWriteData = destVal;
        // Writes to r0 are dropped here
        nextPacket.regWrite     = ctrl.regWrite && (destReg != 5'd0);
        nextPacket.aluOp        = ctrl.aluOp;
        nextPacket.memRead      = ctrl.memRead;
        nextPacket.memWrite     = ctrl.memWrite;
        nextPacket.shamt        = instr[10:6];
        nextPacket.sys          = ctrl.sys;
    end

    // **************************************************************************
    // Output register
    // **************************************************************************

    // Take the head when the slot is free or draining
    // Hold off while the flush pulse is out so the wrong-path successor is dropped
    assign accept = headValid && (!exeValid || exeReady) && !altPcValid;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            exeOut     <= '0;
            exeValid   <= 1'b0;
            altPc      <= '0;
            altPcValid <= 1'b0;
        end else begin
            altPcValid <= accept && taken;
            if (accept) begin
                exeOut   <= nextPacket;
                exeValid <= 1'b1;
                if (taken)
                    altPc <= target;
            end else if (exeReady) begin
                exeValid <= 1'b0;
            end
        end
    end

    // Fetch waits while a syscall sits in the output register
    assign wantFreeze = exeValid && exeOut.sys;

    assert property (@(posedge CLK) disable iff (!RESET)
        altPcValid |=> !altPcValid);

    // Stalled packet stays put
    assert property (@(posedge CLK) disable iff (!RESET)
        exeValid && !exeReady |=> exeValid && $stable(exeOut));

endmodule

/* src/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  decodePkg::word_t       instr,
    output decodePkg::decodeCtrl_t ctrl
);
    import decodePkg::*;

    always_comb begin
        // Unknown encodings fall through as a no-op
        ctrl = '0;
        case (instr[31:26])
            opSpecial: begin
                ctrl.regDst = 1'b1;
                case (instr[5:0])
                    fnAddu: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluAdd;
                    end
                    fnSubu: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluSub;
                    end
                    fnAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluAnd;
                    end
                    fnOr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluOr;
                    end
                    fnSlt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluSlt;
                    end
                    fnSll: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluSll;
                    end
                    // Jump to rs, nothing written back
                    fnJr: begin
                        ctrl.jump    = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    fnSyscall: ctrl.sys = 1'b1;
                    default: ctrl = '0;
                endcase
            end
            opJ: ctrl.jump = 1'b1;
            // Return address goes to r31 through the ALU
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opBeq: begin
                ctrl.branch  = 1'b1;
                ctrl.signExt = 1'b1;
                ctrl.aluOp   = aluSub;
            end
            opBne: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            opAddiu: begin
                ctrl.signExt  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            // Logical immediates are zero-extended
            opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOr;
            end
            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluLui;
            end
            // Address is rs plus the signed offset
            opLw: begin
                ctrl.signExt  = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opSw: begin
                ctrl.signExt  = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* src/instrQueue.sv */
`timescale 1ns/1ps

module instrQueue #(
    parameter int queueDepth = 8
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   flush,
    input  decodePkg::fetchEntry_t enqData,
    input  logic                   enqValid,
    output logic                   enqReady,
    output decodePkg::fetchEntry_t deqData,
    output logic                   deqValid,
    input  logic                   deqReady
);
    import decodePkg::*;

    // Depth is a power of two so the pointers wrap on their own
    localparam int ptrWidth   = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int countWidth = $clog2(queueDepth + 1);

    fetchEntry_t entries [queueDepth];
    logic [ptrWidth-1:0]   rdPtr;
    logic [ptrWidth-1:0]   wrPtr;
    logic [countWidth-1:0] count;
    logic                  doEnq;
    logic                  doDeq;

    assign enqReady = (count != countWidth'(queueDepth));
    assign deqValid = (count != '0);
    assign deqData  = entries[rdPtr];
    assign doEnq    = enqValid && enqReady;
    assign doDeq    = deqValid && deqReady;

    // Pointer and occupancy update
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            // Flush empties the queue and drops any enqueue in the same cycle
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doEnq)
                wrPtr <= wrPtr + 1'b1;
            if (doDeq)
                rdPtr <= rdPtr + 1'b1;
            if (doEnq && !doDeq)
                count <= count + 1'b1;
            else if (doDeq && !doEnq)
                count <= count - 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge CLK) begin
        if (doEnq)
            entries[wrPtr] <= enqData;
    end

    assert property (@(posedge CLK) disable iff (!RESET)
        count <= countWidth'(queueDepth));

    // Write pointer leads the read pointer by the occupancy
    assert property (@(posedge CLK) disable iff (!RESET)
        wrPtr == ptrWidth'(rdPtr + count));

endmodule

/* src/operandBypass.sv */
`timescale 1ns/1ps

module operandBypass (
    input  decodePkg::regIdx_t readReg,
    input  decodePkg::word_t   rawValue,
    input  decodePkg::bypass_t exeBypass,
    input  decodePkg::bypass_t memBypass,
    input  decodePkg::bypass_t wbPort,
    output decodePkg::word_t   value
);

    always_comb begin
        value = rawValue;
        // r0 never takes a forwarded value
        if (readReg != '0) begin
            // Youngest result wins
            if (exeBypass.valid && (exeBypass.dest == readReg))
                value = exeBypass.data;
            else if (memBypass.valid && (memBypass.dest == readReg))
                value = memBypass.data;
            // Covers the register being written this cycle
            else if (wbPort.valid && (wbPort.dest == readReg))
                value = wbPort.data;
        end
    end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic               CLK,
    input  logic               RESET,
    input  decodePkg::regIdx_t readA,
    input  decodePkg::regIdx_t readB,
    input  decodePkg::regIdx_t readC,
    input  decodePkg::bypass_t wbPort,
    output decodePkg::word_t   dataA,
    output decodePkg::word_t   dataB,
    output decodePkg::word_t   dataC
);
    import decodePkg::*;

    // Architectural registers
    word_t regs [32];

    // Single write port from writeback
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wbPort.valid && (wbPort.dest != '0)) begin
            regs[wbPort.dest] <= wbPort.data;
        end
    end

    // Three asynchronous reads
    // r0 is hardwired to zero
    assign dataA = (readA == '0) ? '0 : regs[readA];
    assign dataB = (readB == '0) ? '0 : regs[readB];
    assign dataC = (readC == '0) ? '0 : regs[readC];

endmodule

/* tb/decodeStageTb.sv */
`timescale 1ns/1ps

module decodeStageTb;
    import decodePkg::*;

    // One table row with the expected packet
    typedef struct packed {
        word_t      instr;
        word_t      pc;
        bypass_t    exe;
        bypass_t    mem;
        bypass_t    wb;
        word_t      opA;
        word_t      opB;
        regIdx_t    regA;
        regIdx_t    regB;
        regIdx_t    dest;
        logic [3:0] aluOp;
        logic [4:0] shamt;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        word_t      storeData;
        logic       sys;
        logic       taken;
        word_t      target;
        logic       dropNext;
    } row_t;

    logic        CLK;
    logic        RESET;
    fetchEntry_t fetchIn;
    logic        fetchValid;
    logic        fetchReady;
    bypass_t     wbPort;
    bypass_t     exeBypass;
    bypass_t     memBypass;
    exePacket_t  exeOut;
    logic        exeValid;
    logic        exeReady;
    word_t       altPc;
    logic        altPcValid;
    logic        wantFreeze;

    row_t  rows [40];
    string names [40];
    int    nRows = 0;
    int    cycles = 0;
    logic  tableReady = 1'b0;
    int    seed = 32'h78f4051b;
    word_t expQueue [$];

    decodeStage #(.queueDepth(4)) DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // ************************************************************************
    // Instruction encoders and table builders
    // ************************************************************************

    function automatic word_t rType(int rs, int rt, int rd, int sh, logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t jType(logic [5:0] op, logic [25:0] index);
        return {op, index};
    endfunction

    task automatic addRow(string name, word_t instr, word_t pc, word_t opA, word_t opB,
                          int regA, int regB, int dest, logic [3:0] alu, logic regWrite);
        row_t r;
        r = '0;
        r.instr = instr;
        r.pc = pc;
        r.opA = opA;
        r.opB = opB;
        r.regA = 5'(regA);
        r.regB = 5'(regB);
        r.dest = 5'(dest);
        r.aluOp = alu;
        r.regWrite = regWrite;
        names[nRows] = name;
        rows[nRows] = r;
        nRows++;
    endtask

    task automatic setBypass(bypass_t exe, bypass_t mem, bypass_t wb);
        rows[nRows-1].exe = exe;
        rows[nRows-1].mem = mem;
        rows[nRows-1].wb  = wb;
    endtask

    task automatic setRedirect(word_t target, logic dropNext);
        rows[nRows-1].taken    = 1'b1;
        rows[nRows-1].target   = target;
        rows[nRows-1].dropNext = dropNext;
    endtask

    initial begin
        bypass_t none;
        none = '0;
        // Register setup through writeback
        // The NOP reads only r0
        addRow("wbR1", 32'h0, 32'h0, 0, 0, 0, 0, 0, aluSll, 0);
        setBypass(none, none, '{5'd1, 32'h0000_0005, 1'b1});
        addRow("wbR2", 32'h0, 32'h4, 0, 0, 0, 0, 0, aluSll, 0);
        setBypass(none, none, '{5'd2, 32'hffff_fff0, 1'b1});
        addRow("wbR3", 32'h0, 32'h8, 0, 0, 0, 0, 0, aluSll, 0);
        setBypass(none, none, '{5'd3, 32'h0f0f_1234, 1'b1});
        addRow("wbR0", rType(0, 0, 4, 0, fnAddu), 32'hc, 0, 0, 0, 0, 4, aluAdd, 1);
        setBypass(none, none, '{5'd0, 32'hdead_beef, 1'b1});
        // R-type
        addRow("addu", rType(1, 2, 5, 0, fnAddu), 32'h10, 5, 32'hffff_fff0,
               1, 2, 5, aluAdd, 1);
        addRow("subu", rType(2, 1, 6, 0, fnSubu), 32'h14, 32'hffff_fff0, 5,
               2, 1, 6, aluSub, 1);
        addRow("and", rType(3, 2, 7, 0, fnAnd), 32'h18, 32'h0f0f_1234, 32'hffff_fff0,
               3, 2, 7, aluAnd, 1);
        addRow("or", rType(1, 3, 8, 0, fnOr), 32'h1c, 5, 32'h0f0f_1234,
               1, 3, 8, aluOr, 1);
        addRow("slt", rType(2, 1, 9, 0, fnSlt), 32'h20, 32'hffff_fff0, 5,
               2, 1, 9, aluSlt, 1);
        addRow("sll", rType(0, 3, 10, 4, fnSll), 32'h24, 0, 32'h0f0f_1234,
               0, 3, 10, aluSll, 1);
        rows[nRows-1].shamt = 5'd4;
        // Immediates and memory
        addRow("addiu", iType(opAddiu, 1, 11, 16'hfffc), 32'h28, 5, 32'hffff_fffc,
               1, 0, 11, aluAdd, 1);
        addRow("ori", iType(opOri, 3, 12, 16'h8001), 32'h2c, 32'h0f0f_1234, 32'h8001,
               3, 0, 12, aluOr, 1);
        addRow("lui", iType(opLui, 0, 13, 16'h1234), 32'h30, 0, 32'h1234_0000,
               0, 0, 13, aluLui, 1);
        addRow("lw", iType(opLw, 1, 14, 16'h0008), 32'h34, 5, 8, 1, 0, 14, aluAdd, 1);
        rows[nRows-1].memRead = 1'b1;
        addRow("sw", iType(opSw, 1, 2, 16'h0004), 32'h38, 5, 4, 1, 0, 2, aluAdd, 0);
        rows[nRows-1].memWrite  = 1'b1;
        rows[nRows-1].storeData = 32'hffff_fff0;
        // Forwarding priority
        addRow("fwdExe", rType(20, 2, 15, 0, fnAddu), 32'h3c, 32'h111, 32'hffff_fff0,
               20, 2, 15, aluAdd, 1);
        setBypass('{5'd20, 32'h111, 1'b1}, '{5'd20, 32'h222, 1'b1}, '{5'd20, 32'h333, 1'b1});
        addRow("fwdMem", rType(21, 1, 16, 0, fnAddu), 32'h40, 32'h222, 5,
               21, 1, 16, aluAdd, 1);
        setBypass(none, '{5'd21, 32'h222, 1'b1}, '{5'd21, 32'h444, 1'b1});
        addRow("fwdR0", rType(0, 1, 16, 0, fnAddu), 32'h44, 0, 5, 0, 1, 16, aluAdd, 1);
        setBypass('{5'd0, 32'h999, 1'b1}, '{5'd0, 32'h888, 1'b1}, none);
        // Values left behind by the forwarding writebacks
        addRow("wbKept", rType(20, 21, 17, 0, fnAddu), 32'h48, 32'h333, 32'h444,
               20, 21, 17, aluAdd, 1);
        // Redirects
        addRow("beqTaken", iType(opBeq, 1, 1, 16'h0003), 32'h100, 5, 5,
               1, 1, 1, aluSub, 0);
        setRedirect(32'h110, 1'b0);
        addRow("bneNot", iType(opBne, 1, 1, 16'h0003), 32'h200, 5, 5,
               1, 1, 1, aluSub, 0);
        addRow("bneTaken", iType(opBne, 1, 2, 16'hfffe), 32'h300, 5, 32'hffff_fff0,
               1, 2, 2, aluSub, 0);
        setRedirect(32'h2fc, 1'b0);
        addRow("j", jType(opJ, 26'h40), 32'h1000_0400, 0, 32'h40, 0, 0, 0, aluNop, 0);
        setRedirect(32'h1000_0100, 1'b1);
        addRow("jal", jType(opJal, 26'h100), 32'h2000, 0, 32'h2008, 0, 0, 31, aluAdd, 1);
        setRedirect(32'h400, 1'b1);
        addRow("jr", rType(1, 0, 0, 0, fnJr), 32'h3000, 5, 0, 1, 0, 0, aluNop, 0);
        setRedirect(32'h5, 1'b0);
        // Syscall
        addRow("syscall", rType(0, 0, 0, 0, fnSyscall), 32'h4000, 0, 0,
               0, 0, 0, aluNop, 0);
        rows[nRows-1].sys = 1'b1;
        tableReady = 1'b1;
    end

    // ************************************************************************
    // Checks and handshakes
    // ************************************************************************

    task automatic checkValue(string testName, string field, logic [31:0] expected,
                              logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected %h actual %h", testName, field, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    // Hold the instruction until the queue takes it
    task automatic pushInstr(word_t instr, word_t pc);
        fetchIn    = '{pc, instr};
        fetchValid = 1'b1;
        @(negedge CLK);
        while (!fetchReady)
            @(negedge CLK);
        @(posedge CLK);
        #1;
        fetchValid = 1'b0;
    endtask

    task automatic runRow(int i);
        row_t r;
        r = rows[i];
        exeBypass = r.exe;
        memBypass = r.mem;
        wbPort    = r.wb;
        pushInstr(r.instr, r.pc);
        // Wrong-path successor the flush has to drop
        if (r.dropNext)
            pushInstr(iType(opAddiu, 0, 25, 16'h7777), r.pc + 32'd4);
        @(negedge CLK);
        while (!exeValid)
            @(negedge CLK);
        checkValue(names[i], "instr", r.instr, exeOut.instr);
        checkValue(names[i], "pc", r.pc, exeOut.pc);
        checkValue(names[i], "opA", r.opA, exeOut.opA);
        checkValue(names[i], "opB", r.opB, exeOut.opB);
        checkValue(names[i], "regA", r.regA, exeOut.regA);
        checkValue(names[i], "regB", r.regB, exeOut.regB);
        checkValue(names[i], "destReg", r.dest, exeOut.destReg);
        checkValue(names[i], "aluOp", r.aluOp, exeOut.aluOp);
        checkValue(names[i], "regWrite", r.regWrite, exeOut.regWrite);
        checkValue(names[i], "memRead", r.memRead, exeOut.memRead);
        checkValue(names[i], "memWrite", r.memWrite, exeOut.memWrite);
        checkValue(names[i], "sys", r.sys, exeOut.sys);
        checkValue(names[i], "wantFreeze", r.sys, wantFreeze);
        checkValue(names[i], "altPcValid", r.taken, altPcValid);
        if (r.taken)
            checkValue(names[i], "altPc", r.target, altPc);
        if (r.memWrite)
            checkValue(names[i], "memWriteData", r.storeData, exeOut.memWriteData);
        if (r.aluOp == aluSll)
            checkValue(names[i], "shamt", r.shamt, exeOut.shamt);
        // Drain the packet
        @(posedge CLK);
        #1;
        checkValue(names[i], "wantFreeze before transfer", r.sys, wantFreeze);
        exeReady = 1'b1;
        @(posedge CLK);
        #1;
        exeReady  = 1'b0;
        exeBypass = '0;
        memBypass = '0;
        wbPort    = '0;
        @(negedge CLK);
        checkValue(names[i], "wantFreeze after transfer", 0, wantFreeze);
        if (r.dropNext) begin
            repeat (3) begin
                checkValue(names[i], "exeValid after flush", 0, exeValid);
                @(negedge CLK);
            end
        end
        @(posedge CLK);
        #1;
    endtask

    // Stall, fill the queue, then drain with random gaps
    task automatic drainBackPressure();
        word_t expected;
        int    rnd;
        exeReady = 1'b0;
        for (int k = 1; k <= 5; k++) begin
            pushInstr(iType(opAddiu, 0, 22, 16'(k)), 32'h5000 + 32'(4 * k));
            expQueue.push_back(32'(k));
        end
        @(negedge CLK);
        checkValue("backPressure", "fetchReady", 0, fetchReady);
        checkValue("backPressure", "exeValid", 1, exeValid);
        checkValue("backPressure", "stalled opB", expQueue[0], exeOut.opB);
        repeat (2) @(negedge CLK);
        checkValue("backPressure", "held opB", expQueue[0], exeOut.opB);
        while (expQueue.size() > 0) begin
            @(posedge CLK);
            #1;
            rnd = $random(seed);
            exeReady = rnd[0];
            @(negedge CLK);
            if (exeValid && exeReady) begin
                expected = expQueue.pop_front();
                checkValue("backPressure", "drain opB", expected, exeOut.opB);
            end
        end
        @(posedge CLK);
        #1;
        exeReady = 1'b0;
        @(negedge CLK);
        checkValue("backPressure", "exeValid after drain", 0, exeValid);
    endtask

    // ************************************************************************
    // Main sequence and timeout
    // ************************************************************************

    initial begin
        RESET      = 1'b0;
        fetchIn    = '0;
        fetchValid = 1'b0;
        exeReady   = 1'b0;
        wbPort     = '0;
        exeBypass  = '0;
        memBypass  = '0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b1;
        wait (tableReady);
        @(posedge CLK);
        #1;
        for (int i = 0; i < nRows; i++)
            runRow(i);
        drainBackPressure();
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        wait (tableReady);
        while (cycles <= 20 * nRows + 50) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

endmodule
